//--- design/id_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_pipe_reg (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             in_valid,
	output logic             in_ready,
	input  id_pkg::id_lane_t in_lane1,
	input  id_pkg::id_lane_t in_lane2,
	output logic             out_valid,
	input  logic             out_ready,
	output id_pkg::id_lane_t out_lane1,
	output id_pkg::id_lane_t out_lane2
);

	logic load; // accepted transfer this edge

	// room when empty or being drained now
	assign in_ready = ~out_valid | out_ready;
	assign load     = in_valid & in_ready;

	//////////////////////////////
	// occupancy
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid; // refill, or empty out on drain
		end
	end

	// bundle payload, held while stalled
	always_ff @(posedge clock) begin
		if (load) begin
			out_lane1 <= in_lane1;
			out_lane2 <= in_lane2;
		end
	end

endmodule

`default_nettype wire

//--- design/id_pkg.sv
`default_nettype none

package id_pkg;

	//////////////////////////////
	// widths and fixed values
	//////////////////////////////
	localparam int WORD_W    = 64;
	localparam int INST_W    = 32;
	localparam int REG_IDX_W = 5;
	localparam logic [REG_IDX_W-1:0] ZERO_REG  = 5'd31;    // sink for no writeback
	localparam logic [25:0]          HALT_CODE = 26'h0555; // pal function for halt

	// group opcodes
	localparam logic [5:0] OP_PAL  = 6'h00;
	localparam logic [5:0] OP_INTA = 6'h10;
	localparam logic [5:0] OP_INTL = 6'h11;
	localparam logic [5:0] OP_INTS = 6'h12;
	localparam logic [5:0] OP_INTM = 6'h13;
	localparam logic [5:0] OP_ITFP = 6'h14;
	localparam logic [5:0] OP_FLTV = 6'h15;
	localparam logic [5:0] OP_FLTI = 6'h16;
	localparam logic [5:0] OP_FLTL = 6'h17;
	localparam logic [5:0] OP_MISC = 6'h18;
	localparam logic [5:0] OP_JSR  = 6'h1a;
	localparam logic [5:0] OP_FTPI = 6'h1c;

	// memory and branch opcodes
	localparam logic [5:0] OP_LDA  = 6'h08;
	localparam logic [5:0] OP_LDQ  = 6'h29;
	localparam logic [5:0] OP_STQ  = 6'h2d;
	localparam logic [5:0] OP_BR   = 6'h30;
	localparam logic [5:0] OP_FBEQ = 6'h31;
	localparam logic [5:0] OP_FBLT = 6'h32;
	localparam logic [5:0] OP_FBLE = 6'h33;
	localparam logic [5:0] OP_BSR  = 6'h34;
	localparam logic [5:0] OP_FBNE = 6'h35;
	localparam logic [5:0] OP_FBGE = 6'h36;
	localparam logic [5:0] OP_FBGT = 6'h37;

	// operate func7 codes, shared between groups
	localparam logic [6:0] FN_CMPULT = 7'h1d;
	localparam logic [6:0] FN_ADDQ   = 7'h20;
	localparam logic [6:0] FN_SUBQ   = 7'h29;
	localparam logic [6:0] FN_CMPEQ  = 7'h2d;
	localparam logic [6:0] FN_CMPULE = 7'h3d;
	localparam logic [6:0] FN_CMPLT  = 7'h4d;
	localparam logic [6:0] FN_CMPLE  = 7'h6d;
	localparam logic [6:0] FN_AND    = 7'h00;
	localparam logic [6:0] FN_BIC    = 7'h08;
	localparam logic [6:0] FN_BIS    = 7'h20;
	localparam logic [6:0] FN_ORNOT  = 7'h28;
	localparam logic [6:0] FN_XOR    = 7'h40;
	localparam logic [6:0] FN_EQV    = 7'h48;
	localparam logic [6:0] FN_SRL    = 7'h34;
	localparam logic [6:0] FN_SLL    = 7'h39;
	localparam logic [6:0] FN_SRA    = 7'h3c;
	localparam logic [6:0] FN_MULQ   = 7'h20;

	//////////////////////////////
	// enums
	//////////////////////////////
	typedef enum logic [4:0] {
		alu_addq, alu_subq, alu_cmpeq, alu_cmplt, alu_cmple, alu_cmpult, alu_cmpule,
		alu_and, alu_bic, alu_bis, alu_ornot, alu_xor, alu_eqv,
		alu_srl, alu_sll, alu_sra, alu_mulq
	} alu_func_e;

	typedef enum logic [1:0] {opa_rega, opa_mem_disp, opa_npc, opa_not3} opa_sel_e;
	typedef enum logic [1:0] {opb_regb, opb_alu_imm, opb_br_disp} opb_sel_e;
	typedef enum logic [1:0] {dest_regc, dest_rega, dest_none} dest_sel_e;
	typedef enum logic [1:0] {fu_adder, fu_multiplier, fu_memory} fu_sel_e;

	//////////////////////////////
	// instruction word views
	//////////////////////////////
	typedef struct packed {
		logic [5:0]           opcode;
		logic [REG_IDX_W-1:0] ra;
		logic [REG_IDX_W-1:0] rb;
		logic [15:0]          disp16;
	} mem_fmt_t;

	typedef struct packed {
		logic [REG_IDX_W-1:0] rb;
		logic [2:0]           sbz; // should be zero in reg form
	} opb_reg_t;

	// bits 20..13 are rb or an 8 bit literal, picked by is_lit
	typedef union packed {
		opb_reg_t   r;
		logic [7:0] lit8;
	} opb_src_u;

	typedef struct packed {
		logic [5:0]           opcode;
		logic [REG_IDX_W-1:0] ra;
		opb_src_u             src;
		logic                 is_lit;
		logic [6:0]           func7;
		logic [REG_IDX_W-1:0] rc;
	} op_fmt_t;

	typedef struct packed {
		logic [5:0]           opcode;
		logic [REG_IDX_W-1:0] ra;
		logic [20:0]          disp21; // word offset
	} br_fmt_t;

	typedef union packed {
		mem_fmt_t mem;
		op_fmt_t  op;
		br_fmt_t  br;
	} inst_u;

	//////////////////////////////
	// lane bundles
	//////////////////////////////
	typedef struct packed {
		inst_u             inst;
		logic              valid;
		logic [WORD_W-1:0] npc;
	} id_in_t;

	typedef struct packed {
		opa_sel_e  opa_sel;
		opb_sel_e  opb_sel;
		dest_sel_e dest_sel;
		alu_func_e alu_func;
		fu_sel_e   fu_sel;
		logic      rd_mem;
		logic      wr_mem;
		logic      cond_br;
		logic      uncond_br;
		logic      halt;
		logic      illegal;
		logic      valid_inst;
	} dec_ctl_t;

	typedef struct packed {
		logic [WORD_W-1:0]    opa;
		logic [WORD_W-1:0]    opb;
		logic                 opa_is_value; // low means opa holds a reg tag
		logic                 opb_is_value;
		logic [REG_IDX_W-1:0] dest_idx;
		logic [REG_IDX_W-1:0] rega_idx;
		alu_func_e            alu_func;
		fu_sel_e              fu_sel;
		logic                 rd_mem;
		logic                 wr_mem;
		logic                 cond_br;
		logic                 uncond_br;
		logic                 halt;
		logic                 illegal;
		logic                 valid_inst;
	} id_lane_t;

endpackage

`default_nettype wire

//--- design/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             in_valid,  // from fetch
	output logic             in_ready,
	input  id_pkg::id_in_t   in_lane1,  // older instruction
	input  id_pkg::id_in_t   in_lane2,
	output logic             out_valid, // to rename
	input  logic             out_ready,
	output id_pkg::id_lane_t out_lane1,
	output id_pkg::id_lane_t out_lane2
);
	import id_pkg::*;

	dec_ctl_t ctl1, ctl2;
	id_lane_t res1, res2; // unregistered lane results

	//////////////////////////////
	// lane 1
	//////////////////////////////
	inst_decoder u_dec1 (
		.inst     (in_lane1.inst),
		.valid_in (in_lane1.valid),
		.ctl      (ctl1)
	);

	operand_select u_opsel1 (
		.lane_in  (in_lane1),
		.ctl      (ctl1),
		.lane_out (res1)
	);

	//////////////////////////////
	// lane 2
	//////////////////////////////
	inst_decoder u_dec2 (
		.inst     (in_lane2.inst),
		.valid_in (in_lane2.valid),
		.ctl      (ctl2)
	);

	operand_select u_opsel2 (
		.lane_in  (in_lane2),
		.ctl      (ctl2),
		.lane_out (res2)
	);

	// one cycle output stage
	id_pipe_reg u_pipe (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_lane1  (res1),
		.in_lane2  (res2),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_lane1 (out_lane1),
		.out_lane2 (out_lane2)
	);

endmodule

`default_nettype wire

//--- design/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  id_pkg::inst_u    inst,
	input  logic             valid_in, // low gives the noop result
	output id_pkg::dec_ctl_t ctl
);
	import id_pkg::*;

	logic [5:0] opcode;
	logic [2:0] op_class; // top three opcode bits
	logic [6:0] func7;

	assign opcode   = inst.mem.opcode;
	assign op_class = opcode[5:3];
	assign func7    = inst.op.func7;

	always_comb begin
		// noop defaults
		ctl.opa_sel   = opa_rega;
		ctl.opb_sel   = opb_regb;
		ctl.dest_sel  = dest_none;
		ctl.alu_func  = alu_addq;
		ctl.fu_sel    = fu_adder;
		ctl.rd_mem    = 1'b0;
		ctl.wr_mem    = 1'b0;
		ctl.cond_br   = 1'b0;
		ctl.uncond_br = 1'b0;
		ctl.halt      = 1'b0;
		ctl.illegal   = 1'b0;
		if (valid_in) begin
			case (op_class)
				3'd0: begin // pal only
					if (opcode == OP_PAL && inst[25:0] == HALT_CODE)
						ctl.halt = 1'b1;
					else
						ctl.illegal = 1'b1;
				end
				3'd2: begin // integer operate and fp groups
					ctl.opb_sel  = inst.op.is_lit ? opb_alu_imm : opb_regb;
					ctl.dest_sel = dest_regc;
					case (opcode)
						OP_INTA: case (func7)
							FN_CMPULT: ctl.alu_func = alu_cmpult;
							FN_ADDQ:   ctl.alu_func = alu_addq;
							FN_SUBQ:   ctl.alu_func = alu_subq;
							FN_CMPEQ:  ctl.alu_func = alu_cmpeq;
							FN_CMPULE: ctl.alu_func = alu_cmpule;
							FN_CMPLT:  ctl.alu_func = alu_cmplt;
							FN_CMPLE:  ctl.alu_func = alu_cmple;
							default:   ctl.illegal  = 1'b1;
						endcase
						OP_INTL: case (func7)
							FN_AND:   ctl.alu_func = alu_and;
							FN_BIC:   ctl.alu_func = alu_bic;
							FN_BIS:   ctl.alu_func = alu_bis;
							FN_ORNOT: ctl.alu_func = alu_ornot;
							FN_XOR:   ctl.alu_func = alu_xor;
							FN_EQV:   ctl.alu_func = alu_eqv;
							default:  ctl.illegal  = 1'b1;
						endcase
						OP_INTS: case (func7)
							FN_SRL:  ctl.alu_func = alu_srl;
							FN_SLL:  ctl.alu_func = alu_sll;
							FN_SRA:  ctl.alu_func = alu_sra;
							default: ctl.illegal  = 1'b1;
						endcase
						OP_INTM: begin
							if (func7 == FN_MULQ)
								ctl.alu_func = alu_mulq;
							else
								ctl.illegal = 1'b1;
						end
						OP_ITFP, OP_FLTV, OP_FLTI, OP_FLTL: ctl.illegal = 1'b1; // no fp
						default: ctl.illegal = 1'b1;
					endcase
				end
				3'd3: begin
					case (opcode)
						OP_JSR: begin // jmp/jsr/ret/jsr_co all alike
							ctl.opa_sel   = opa_not3;
							ctl.alu_func  = alu_and; // word-align the target
							ctl.dest_sel  = dest_rega;
							ctl.uncond_br = 1'b1;
						end
						OP_MISC, OP_FTPI: ctl.illegal = 1'b1;
						default:          ctl.illegal = 1'b1;
					endcase
				end
				3'd1, 3'd4, 3'd5: begin // memory, address = disp + rb
					ctl.opa_sel  = opa_mem_disp;
					ctl.dest_sel = dest_rega;
					case (opcode)
						OP_LDA: ; // address only
						OP_LDQ: ctl.rd_mem = 1'b1;
						OP_STQ: begin
							ctl.wr_mem   = 1'b1;
							ctl.dest_sel = dest_none;
						end
						default: ctl.illegal = 1'b1;
					endcase
				end
				default: begin // classes 6 and 7, branches
					ctl.opa_sel = opa_npc;
					ctl.opb_sel = opb_br_disp;
					case (opcode)
						OP_FBEQ, OP_FBLT, OP_FBLE,
						OP_FBNE, OP_FBGE, OP_FBGT: ctl.illegal = 1'b1;
						OP_BR, OP_BSR: begin
							ctl.dest_sel  = dest_rega; // link reg
							ctl.uncond_br = 1'b1;
						end
						default: ctl.cond_br = 1'b1; // integer conditionals
					endcase
				end
			endcase
			// unit select follows the class, mulq overrides
			if (op_class == 3'd1 || op_class == 3'd4 || op_class == 3'd5)
				ctl.fu_sel = fu_memory;
			else if (ctl.alu_func == alu_mulq)
				ctl.fu_sel = fu_multiplier;
		end
		ctl.valid_inst = valid_in & ~ctl.illegal;
	end

endmodule

`default_nettype wire

//--- design/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select (
	input  id_pkg::id_in_t   lane_in,
	input  id_pkg::dec_ctl_t ctl,
	output id_pkg::id_lane_t lane_out
);
	import id_pkg::*;

	logic [WORD_W-1:0]    mem_disp;
	logic [WORD_W-1:0]    br_disp;
	logic [WORD_W-1:0]    alu_imm;
	logic [REG_IDX_W-1:0] ra, rb, rc;

	//////////////////////////////
	// immediates
	//////////////////////////////
	assign mem_disp = {{(WORD_W-16){lane_in.inst.mem.disp16[15]}}, lane_in.inst.mem.disp16};
	assign br_disp  = {{(WORD_W-23){lane_in.inst.br.disp21[20]}}, lane_in.inst.br.disp21, 2'b00};
	assign alu_imm  = {{(WORD_W-8){1'b0}}, lane_in.inst.op.src.lit8}; // zero-ext literal

	assign ra = lane_in.inst.mem.ra;
	assign rb = lane_in.inst.mem.rb; // same bits in every format
	assign rc = lane_in.inst.op.rc;

	always_comb begin
		// opa mux
		lane_out.opa_is_value = 1'b1;
		case (ctl.opa_sel)
			opa_mem_disp: lane_out.opa = mem_disp;
			opa_npc:      lane_out.opa = lane_in.npc;
			opa_not3:     lane_out.opa = {{(WORD_W-2){1'b1}}, 2'b00}; // align mask
			default: begin // reg tag
				lane_out.opa          = {{(WORD_W-REG_IDX_W){1'b0}}, ra};
				lane_out.opa_is_value = 1'b0;
			end
		endcase

		// opb mux
		lane_out.opb_is_value = 1'b1;
		case (ctl.opb_sel)
			opb_alu_imm: lane_out.opb = alu_imm;
			opb_br_disp: lane_out.opb = br_disp;
			default: begin
				lane_out.opb          = {{(WORD_W-REG_IDX_W){1'b0}}, rb};
				lane_out.opb_is_value = 1'b0;
			end
		endcase

		case (ctl.dest_sel)
			dest_regc: lane_out.dest_idx = rc;
			dest_rega: lane_out.dest_idx = ra;
			default:   lane_out.dest_idx = ZERO_REG; // no writeback
		endcase

		lane_out.rega_idx   = ra; // travels on for rename
		lane_out.alu_func   = ctl.alu_func;
		lane_out.fu_sel     = ctl.fu_sel;
		lane_out.rd_mem     = ctl.rd_mem;
		lane_out.wr_mem     = ctl.wr_mem;
		lane_out.cond_br    = ctl.cond_br;
		lane_out.uncond_br  = ctl.uncond_br;
		lane_out.halt       = ctl.halt;
		lane_out.illegal    = ctl.illegal;
		lane_out.valid_inst = ctl.valid_inst;
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_id_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_id_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1

//--- tb.f
design/id_pkg.sv
design/inst_decoder.sv
design/operand_select.sv
design/id_pipe_reg.sv
design/id_stage.sv
tb/id_stage_chk.sv
tb/tb_id_stage.sv

//--- tb/id_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_chk (
	input logic             clock,
	input logic             rst_n,
	input logic             out_valid,
	input logic             out_ready,
	input id_pkg::id_lane_t out_lane1,
	input id_pkg::id_lane_t out_lane2
);
	import id_pkg::*;

	// output register empty right after reset
	a_reset_empty: assert property (@(posedge clock) !rst_n |=> !out_valid)
		else $error("out_valid high one cycle after reset");

	//////////////////////////////
	// stall holds the bundle
	//////////////////////////////
	a_hold: assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_lane1) && $stable(out_lane2))
		else $error("output bundle changed while stalled");

	a_illegal1: assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && out_lane1.illegal |-> !out_lane1.valid_inst)
		else $error("lane1 illegal with valid_inst set");
	a_illegal2: assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && out_lane2.illegal |-> !out_lane2.valid_inst)
		else $error("lane2 illegal with valid_inst set");

	// stores never write back
	a_store1: assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && out_lane1.wr_mem |-> out_lane1.dest_idx == ZERO_REG)
		else $error("lane1 store with a destination register");
	a_store2: assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && out_lane2.wr_mem |-> out_lane2.dest_idx == ZERO_REG)
		else $error("lane2 store with a destination register");

endmodule

bind id_stage id_stage_chk i_chk (
	.clock     (clock),
	.rst_n     (rst_n),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_lane1 (out_lane1),
	.out_lane2 (out_lane2)
);

`default_nettype wire

//--- tb/id_vectors.mem
// one lane per line, two lines per bundle: inst valid npc, then expected
// opa opb is_value{opa,opb} dest rega alu_func fu_sel flags{rd,wr,cbr,ubr,halt,ill,vld}
402203a3 1 1000 1 2 0 03 01 05 0 01
403ff403 1 1004 1 ff 1 03 01 00 0 01
40220523 1 1008 1 2 0 03 01 01 0 01
4020b5a3 1 100c 1 5 1 03 01 02 0 01
402207a3 1 1010 1 2 0 03 01 06 0 01
402209a3 1 1014 1 2 0 03 01 03 0 01
40301da3 1 1018 1 80 1 03 01 04 0 01
4489000a 1 101c 4 9 0 0a 04 07 0 01
4482110a 1 1020 4 10 1 0a 04 08 0 01
4489040a 1 1024 4 9 0 0a 04 09 0 01
4489050a 1 1028 4 9 0 0a 04 0a 0 01
4487f80a 1 102c 4 3f 1 0a 04 0b 0 01
4489090a 1 1030 4 9 0 0a 04 0c 0 01
48be0687 1 1034 5 1e 0 07 05 0d 0 01
48a0b727 1 1038 5 5 1 07 05 0e 0 01
48be0787 1 103c 5 1e 0 07 05 0f 0 01
4c430404 1 1040 2 3 0 04 02 10 1 01
4c5ff404 1 1044 2 ff 1 04 02 10 1 01
20220010 1 2000 10 2 2 01 01 00 2 01
a47efff8 1 2004 fffffffffffffff8 1e 2 03 03 00 2 41
b4828000 1 2008 ffffffffffff8000 2 2 1f 04 00 2 21
6b5b4000 1 200c fffffffffffffffc 1b 2 1a 1a 07 0 09
c0400010 1 3000 3000 40 3 02 02 00 0 09
d35fffff 1 3004 3004 fffffffffffffffc 3 1a 1a 00 0 09
e4b00000 1 3008 3008 ffffffffffc00000 3 1f 05 00 0 11
f4e00100 1 300c 300c 400 3 1f 07 00 0 11
00000555 1 4000 0 0 0 1f 00 00 0 05
58220403 1 4004 1 2 0 03 01 00 0 02
60224000 1 4008 1 2 0 1f 01 00 0 02
40220fe3 1 400c 1 2 0 03 01 00 0 02
c4200010 1 4010 4010 40 3 1f 01 00 0 02
a47efff8 0 4014 3 1e 0 1f 03 00 0 00

//--- tb/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
	import id_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYC  = 16;
	localparam int NUM_VEC    = 16;
	localparam int FIELDS     = 11; // numbers per lane line in the vector file
	localparam int TIMEOUT_NS = (RESET_CYC + NUM_VEC * 40) * CLK_PERIOD;

	typedef struct packed {
		int       idx; // vector number, names the test
		id_lane_t lane1;
		id_lane_t lane2;
	} bundle_t;

	logic     clock     = 1'b0;
	logic     rst_n;
	logic     in_valid;
	logic     in_ready;
	id_in_t   in_lane1;
	id_in_t   in_lane2;
	logic     out_valid;
	logic     out_ready = 1'b0;
	id_lane_t out_lane1;
	id_lane_t out_lane2;

	logic [63:0] vec_mem [0:NUM_VEC*2*FIELDS-1];
	bundle_t     exp_q[$];          // bundles accepted, not yet seen at the output
	integer      seed     = 32'hc920;
	logic        take     = 1'b0;   // input transfer at the coming edge
	int          sent     = 0;
	int          checked  = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	int          err_cnt  = 0;

	string test_name [NUM_VEC] = '{
		"inta_cmpult_addq", "inta_subq_cmpeq", "inta_cmpule_cmplt", "inta_cmple_intl_and",
		"intl_bic_bis", "intl_ornot_xor", "intl_eqv_ints_srl", "ints_sll_sra",
		"intm_mulq", "mem_lda_ldq", "mem_stq_jsr", "branch_br_bsr",
		"branch_beq_bne", "halt_flti", "misc_bad_func", "fbeq_invalid_lane"
	};

	id_stage i_dut (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_lane1  (in_lane1),
		.in_lane2  (in_lane2),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_lane1 (out_lane1),
		.out_lane2 (out_lane2)
	);

	always #(CLK_PERIOD/2) clock = ~clock;

	//////////////////////////////
	// vector file unpacking
	//////////////////////////////
	function automatic id_in_t lane_stim(input int base);
		id_in_t l;
		l.inst  = vec_mem[base][INST_W-1:0];
		l.valid = vec_mem[base+1][0];
		l.npc   = vec_mem[base+2];
		return l;
	endfunction

	function automatic id_lane_t lane_expect(input int base);
		id_lane_t l;
		l.opa          = vec_mem[base+3];
		l.opb          = vec_mem[base+4];
		l.opa_is_value = vec_mem[base+5][1];
		l.opb_is_value = vec_mem[base+5][0];
		l.dest_idx     = vec_mem[base+6][REG_IDX_W-1:0];
		l.rega_idx     = vec_mem[base+7][REG_IDX_W-1:0];
		l.alu_func     = alu_func_e'(vec_mem[base+8][4:0]);
		l.fu_sel       = fu_sel_e'(vec_mem[base+9][1:0]);
		{l.rd_mem, l.wr_mem, l.cond_br, l.uncond_br,
			l.halt, l.illegal, l.valid_inst} = vec_mem[base+10][6:0];
		return l;
	endfunction

	task automatic expect_bundle(input int v);
		bundle_t b;
		b.idx   = v;
		b.lane1 = lane_expect(v * 2 * FIELDS);
		b.lane2 = lane_expect((v * 2 + 1) * FIELDS);
		exp_q.push_back(b);
	endtask

	// handshake outputs against the bundles in flight
	task automatic verify_handshake();
		logic held; // output register should hold a bundle
		held = (exp_q.size() != 0);
		assert (out_valid === held) else begin
			err_cnt++;
			$display("error handshake out_valid expected %b actual %b", held, out_valid);
		end
		assert (in_ready === (!held || out_ready)) else begin
			err_cnt++;
			$display("error handshake in_ready expected %b actual %b",
				!held || out_ready, in_ready);
		end
	endtask

	// compare the bundle leaving the stage with the oldest accepted one
	task automatic check_bundle();
		bundle_t b;
		bit      ok;
		if (exp_q.size() == 0) begin
			err_cnt++;
			$display("output bundle appeared with nothing left to expect");
		end else begin
			b  = exp_q.pop_front();
			ok = 1'b1;
			assert (out_lane1 === b.lane1) else begin
				$display("error %s lane1 expected %h actual %h",
					test_name[b.idx], b.lane1, out_lane1);
				ok = 1'b0;
			end
			assert (out_lane2 === b.lane2) else begin
				$display("error %s lane2 expected %h actual %h",
					test_name[b.idx], b.lane2, out_lane2);
				ok = 1'b0;
			end
			if (ok)
				pass_cnt++;
			else
				fail_cnt++;
			$display("test %s %s", test_name[b.idx], ok ? "ok" : "failed");
			checked++;
		end
	endtask

	// mid-cycle sampling, inputs and outputs settled
	always @(negedge clock) begin
		if (rst_n) begin
			verify_handshake();
			if (out_valid && out_ready)
				check_bundle();
			if (in_valid && in_ready) begin
				expect_bundle(sent);
				sent++;
			end
			take <= in_valid && in_ready;
		end else begin
			take <= 1'b0;
		end
	end

	// consumer back-pressure
	always @(posedge clock) begin
		if (!rst_n)
			out_ready <= 1'b0;
		else
			out_ready <= ($random(seed) & 3) != 0; // drop about one cycle in four
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////
	initial begin
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_lane1 = '0;
		in_lane2 = '0;
		$readmemh("tb/id_vectors.mem", vec_mem);
		repeat (RESET_CYC) @(posedge clock);
		rst_n <= 1'b1;
		for (int v = 0; v < NUM_VEC; v++) begin
			in_valid <= 1'b1;
			in_lane1 <= lane_stim(v * 2 * FIELDS);
			in_lane2 <= lane_stim((v * 2 + 1) * FIELDS);
			@(posedge clock);
			while (!take) @(posedge clock); // hold until the stage takes it
		end
		in_valid <= 1'b0;
		wait (checked == NUM_VEC);
		repeat (4) @(posedge clock); // catch any stray extra bundle
		$display("tests run %0d passed %0d failed %0d other errors %0d",
			checked, pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired with %0d of %0d bundles checked", checked, NUM_VEC);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
